// ==== flist.f ====
logic/wb_cfg_pkg.sv
logic/riscv_isa_pkg.sv
logic/trap_if.sv
logic/load_store_unit.sv
logic/csr_file.sv
logic/trap_control.sv
logic/wb_stage.sv
verification/wb_stage_props.sv
verification/wb_stage_tb.sv

// ==== logic/csr_file.sv ====
// machine-mode CSRs (mstatus, mie, mtvec, mepc, mcause, mip) with the
// read mux and the interrupt entry / mret updates
`timescale 1ns/100ps
`default_nettype none

module csr_file (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [11:0]                    csr_addr,
  input  logic                           csr_wr,
  input  logic                           csr_rd,
  input  logic [wb_cfg_pkg::xlen-1:0]    wdata,
  input  logic [wb_cfg_pkg::xlen-1:0]    pc,
  input  logic [wb_cfg_pkg::num_irq-1:0] interrupt,
  output logic [wb_cfg_pkg::xlen-1:0]    rdata,
  trap_if.csr_side                       trap
);
  import riscv_isa_pkg::*;
  import wb_cfg_pkg::*;

  logic               global_ie_q;
  logic               saved_ie_q;
  logic [num_irq-1:0] mie_q;
  logic [xlen-1:0]    mtvec_q;
  logic [xlen-1:0]    mepc_q;
  logic [xlen-1:0]    mcause_q;
  logic [xlen-1:0]    trap_cause;
  logic [xlen-1:0]    mstatus_rd;
  logic [xlen-1:0]    mie_rd;
  logic [xlen-1:0]    mip_rd;

  // interrupt flag in the top bit, cause number below it
  assign trap_cause = {1'b1, (xlen-1)'(irq_cause_base + int'(trap.trap_index))};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      global_ie_q <= 1'b0;
      saved_ie_q  <= 1'b0;
      mie_q       <= '0;
      mtvec_q     <= '0;
      mepc_q      <= '0;
      mcause_q    <= '0;
    end else if (trap.trap_take) begin
      // interrupt entry, stash the enable and mask further interrupts
      mepc_q      <= pc;
      mcause_q    <= trap_cause;
      saved_ie_q  <= global_ie_q;
      global_ie_q <= 1'b0;
    end else if (trap.mret_take) begin
      global_ie_q <= saved_ie_q;
    end else if (csr_wr) begin
      case (csr_addr)
        csr_mstatus: begin
          global_ie_q <= wdata[mstatus_mie_bit];
          saved_ie_q  <= wdata[mstatus_mpie_bit];
        end
        csr_mie:    mie_q    <= wdata[irq_cause_base +: num_irq];
        csr_mtvec:  mtvec_q  <= wdata;
        csr_mepc:   mepc_q   <= wdata;
        csr_mcause: mcause_q <= wdata;
        // mip is read-only, other addresses ignored
        default: ;
      endcase
    end
  end

  // word images of the sparse registers
  always_comb begin
    mstatus_rd                   = '0;
    mstatus_rd[mstatus_mie_bit]  = global_ie_q;
    mstatus_rd[mstatus_mpie_bit] = saved_ie_q;
    mie_rd                       = '0;
    mie_rd[irq_cause_base +: num_irq] = mie_q;
    mip_rd                       = '0;
    mip_rd[irq_cause_base +: num_irq] = interrupt;
  end

  always_comb begin
    rdata = '0;
    if (csr_rd) begin
      case (csr_addr)
        csr_mstatus: rdata = mstatus_rd;
        csr_mie:     rdata = mie_rd;
        csr_mtvec:   rdata = mtvec_q;
        csr_mepc:    rdata = mepc_q;
        csr_mcause:  rdata = mcause_q;
        csr_mip:     rdata = mip_rd;
        default:     rdata = '0;
      endcase
    end
  end

  assign trap.global_ie  = global_ie_q;
  assign trap.irq_enable = mie_q;
  assign trap.mtvec      = mtvec_q;
  assign trap.mepc       = mepc_q;

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
// store lane alignment and byte mask, load extraction with sign/zero
// extension, and the single-cycle system bus drive
`timescale 1ns/100ps
`default_nettype none

module load_store_unit (
  input  logic [2:0]                         funct3,
  input  logic [wb_cfg_pkg::xlen-1:0]        addr,
  input  logic [wb_cfg_pkg::xlen-1:0]        store_data,
  input  logic                               mem_wr,
  input  logic                               mem_read,
  output logic                               system_bus_en,
  output logic                               system_bus_rdwr,
  output logic [wb_cfg_pkg::xlen-1:0]        system_bus_addr,
  output logic [wb_cfg_pkg::xlen-1:0]        system_bus_wr_data,
  output logic [wb_cfg_pkg::byte_mask_w-1:0] system_bus_mask,
  input  logic [wb_cfg_pkg::xlen-1:0]        system_bus_rd_data,
  output logic [wb_cfg_pkg::xlen-1:0]        load_data
);
  import riscv_isa_pkg::*;
  import wb_cfg_pkg::*;

  logic [byte_mask_w-1:0] store_mask;
  logic [7:0]             ld_byte;
  logic [15:0]            ld_half;

  // no handshake, the bus follows the request directly
  assign system_bus_en   = mem_wr | mem_read;
  assign system_bus_rdwr = mem_wr;
  assign system_bus_addr = addr;

  // replicate the store value so any lane carries it
  always_comb begin
    system_bus_wr_data = store_data;
    store_mask         = '0;
    case (funct3)
      funct3_sb: begin
        system_bus_wr_data = {4{store_data[7:0]}};
        store_mask         = byte_mask_w'(1) << addr[1:0];
      end
      funct3_sh: begin
        system_bus_wr_data = {2{store_data[15:0]}};
        store_mask         = addr[1] ? 4'b1100 : 4'b0011;
      end
      funct3_sw: begin
        store_mask = '1;
      end
      default: store_mask = '0;
    endcase
  end

  // lanes only enabled on an actual store
  assign system_bus_mask = mem_wr ? store_mask : '0;

  // pick the addressed byte and halfword out of the read word
  assign ld_byte = system_bus_rd_data[{addr[1:0], 3'b000} +: 8];
  assign ld_half = addr[1] ? system_bus_rd_data[31:16] : system_bus_rd_data[15:0];

  always_comb begin
    case (funct3)
      funct3_lb:  load_data = {{(xlen-8){ld_byte[7]}}, ld_byte};
      funct3_lh:  load_data = {{(xlen-16){ld_half[15]}}, ld_half};
      funct3_lbu: load_data = {{(xlen-8){1'b0}}, ld_byte};
      funct3_lhu: load_data = {{(xlen-16){1'b0}}, ld_half};
      funct3_lw:  load_data = system_bus_rd_data;
      default:    load_data = system_bus_rd_data;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/riscv_isa_pkg.sv ====
// RV32 instruction field views, load/store funct3 codes,
// machine CSR addresses and interrupt cause numbering
`default_nettype none

package riscv_isa_pkg;

  // I-type system instruction, the immediate holds the CSR number
  typedef struct packed {
    logic [11:0] csr_addr;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } csr_fmt_t;

  // S-type, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } store_fmt_t;

  typedef union packed {
    csr_fmt_t   csr;
    store_fmt_t store;
  } instr_u;

  // load width codes
  localparam logic [2:0] funct3_lb  = 3'b000;
  localparam logic [2:0] funct3_lh  = 3'b001;
  localparam logic [2:0] funct3_lw  = 3'b010;
  localparam logic [2:0] funct3_lbu = 3'b100;
  localparam logic [2:0] funct3_lhu = 3'b101;

  // store width codes
  localparam logic [2:0] funct3_sb = 3'b000;
  localparam logic [2:0] funct3_sh = 3'b001;
  localparam logic [2:0] funct3_sw = 3'b010;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mie     = 12'h304;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;
  localparam logic [11:0] csr_mip     = 12'h344;

  // mstatus bit positions, global enable and its saved copy
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;

  // platform interrupt i reports cause 16 + i, also its mie/mip bit
  localparam int irq_cause_base = 16;

endpackage

`default_nettype wire

// ==== logic/trap_control.sv ====
// interrupt arbitration, mret qualification and the registered PC
// redirect (epc / epc_taken)
`timescale 1ns/100ps
`default_nettype none

module trap_control (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [wb_cfg_pkg::num_irq-1:0] interrupt,
  input  logic                           is_mret,
  output logic [wb_cfg_pkg::xlen-1:0]    epc,
  output logic                           epc_taken,
  trap_if.ctrl_side                      trap
);
  import wb_cfg_pkg::*;

  logic [num_irq-1:0]   pending;
  logic [irq_idx_w-1:0] win_idx;

  // only interrupts that are both raised and enabled compete
  assign pending = interrupt & trap.irq_enable;

  // scan from the top so the lowest set index is left in win_idx
  always_comb begin
    win_idx = '0;
    for (int i = num_irq - 1; i >= 0; i--) begin
      if (pending[i]) begin
        win_idx = irq_idx_w'(i);
      end
    end
  end

  assign trap.trap_take  = trap.global_ie & (|pending);
  assign trap.trap_index = win_idx;
  // an interrupt in the same cycle pre-empts the return
  assign trap.mret_take  = is_mret & ~trap.trap_take;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      epc_taken <= 1'b0;
      epc       <= '0;
    end else begin
      epc_taken <= trap.trap_take | trap.mret_take;
      if (trap.trap_take) begin
        epc <= trap.mtvec;
      end else if (trap.mret_take) begin
        epc <= trap.mepc;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/trap_if.sv ====
// trap state shared by the CSR block and the trap control logic
`timescale 1ns/100ps
`default_nettype none

interface trap_if;
  import wb_cfg_pkg::*;

  // CSR state seen by the trap logic
  logic                 global_ie;
  logic [num_irq-1:0]   irq_enable;
  logic [xlen-1:0]      mtvec;
  logic [xlen-1:0]      mepc;

  // trap logic decisions back to the CSRs
  logic                 trap_take;
  logic [irq_idx_w-1:0] trap_index;
  logic                 mret_take;

  modport csr_side (
    output global_ie, irq_enable, mtvec, mepc,
    input  trap_take, trap_index, mret_take
  );

  modport ctrl_side (
    input  global_ie, irq_enable, mtvec, mepc,
    output trap_take, trap_index, mret_take
  );

endinterface

`default_nettype wire

// ==== logic/wb_cfg_pkg.sv ====
// datapath widths, interrupt count and writeback-select encoding
`default_nettype none

package wb_cfg_pkg;

  // register and bus word width
  localparam int xlen = 32;

  // byte lanes on the system bus
  localparam int byte_mask_w = 4;

  // external interrupt lines
  localparam int num_irq = 4;

  // width of an interrupt index
  localparam int irq_idx_w = $clog2(num_irq);

  // writeback source
  typedef enum logic [1:0] {
    wb_pc4  = 2'd0,
    wb_alu  = 2'd1,
    wb_load = 2'd2,
    wb_csr  = 2'd3
  } wb_sel_e;

endpackage

`default_nettype wire

// ==== logic/wb_stage.sv ====
// writeback stage top with the writeback mux, load/store unit,
// machine CSR block and trap control
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               mem_wr,
  input  logic                               mem_read,
  input  logic                               csr_reg_wr,
  input  logic                               csr_reg_r,
  input  logic                               is_mret,
  input  logic [wb_cfg_pkg::xlen-1:0]        alu_o,
  input  logic [wb_cfg_pkg::xlen-1:0]        pc,
  input  logic [wb_cfg_pkg::xlen-1:0]        mem_wr_data,
  input  logic [wb_cfg_pkg::xlen-1:0]        instruction,
  input  logic [wb_cfg_pkg::xlen-1:0]        rdata1,
  input  wb_cfg_pkg::wb_sel_e                wb_sel,
  input  logic [wb_cfg_pkg::num_irq-1:0]     interrupt,
  output logic [wb_cfg_pkg::xlen-1:0]        wb_data,
  output logic [wb_cfg_pkg::xlen-1:0]        epc,
  output logic                               epc_taken,
  output logic                               system_bus_en,
  output logic                               system_bus_rdwr,
  output logic [wb_cfg_pkg::xlen-1:0]        system_bus_addr,
  output logic [wb_cfg_pkg::xlen-1:0]        system_bus_wr_data,
  output logic [wb_cfg_pkg::byte_mask_w-1:0] system_bus_mask,
  input  logic [wb_cfg_pkg::xlen-1:0]        system_bus_rd_data
);
  import riscv_isa_pkg::*;
  import wb_cfg_pkg::*;

  instr_u          instr_view;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] csr_rdata;

  assign instr_view = instruction;

  trap_if trap_bus ();

  // load/store address comes straight from the ALU
  load_store_unit lsu_inst (
    .funct3             (instr_view.store.funct3),
    .addr               (alu_o),
    .store_data         (mem_wr_data),
    .mem_wr             (mem_wr),
    .mem_read           (mem_read),
    .system_bus_en      (system_bus_en),
    .system_bus_rdwr    (system_bus_rdwr),
    .system_bus_addr    (system_bus_addr),
    .system_bus_wr_data (system_bus_wr_data),
    .system_bus_mask    (system_bus_mask),
    .system_bus_rd_data (system_bus_rd_data),
    .load_data          (load_data)
  );

  csr_file csr_file_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .csr_addr  (instr_view.csr.csr_addr),
    .csr_wr    (csr_reg_wr),
    .csr_rd    (csr_reg_r),
    .wdata     (rdata1),
    .pc        (pc),
    .interrupt (interrupt),
    .rdata     (csr_rdata),
    .trap      (trap_bus.csr_side)
  );

  trap_control trap_control_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .interrupt (interrupt),
    .is_mret   (is_mret),
    .epc       (epc),
    .epc_taken (epc_taken),
    .trap      (trap_bus.ctrl_side)
  );

  // writeback source select
  always_comb begin
    case (wb_sel)
      wb_pc4:  wb_data = pc + xlen'(4);
      wb_alu:  wb_data = alu_o;
      wb_load: wb_data = load_data;
      wb_csr:  wb_data = csr_rdata;
      default: wb_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the writeback stage simulation with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module wb_stage_tb -f flist.f -o wb_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/wb_stage_sim +verilator+error+limit+100 > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Testbench failed" "$log"; then
  exit 1
fi
exit 0

// ==== verification/wb_stage_props.sv ====
// port-level concurrent checks for the writeback stage, bound into wb_stage
`timescale 1ns/100ps
`default_nettype none

module wb_stage_props (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               mem_wr,
  input  logic                               epc_taken,
  input  logic [wb_cfg_pkg::xlen-1:0]        alu_o,
  input  logic [wb_cfg_pkg::xlen-1:0]        system_bus_addr,
  input  logic [wb_cfg_pkg::byte_mask_w-1:0] system_bus_mask
);

  // number of failed properties so far
  int unsigned fail_count = 0;

  // redirect register is held clear by the async reset
  assert property (@(posedge clk) !rst_n |-> !epc_taken)
    else begin
      fail_count++;
      $error("epc_taken high while reset is asserted");
    end

  // redirect is a single-cycle pulse
  assert property (@(posedge clk) disable iff (!rst_n) epc_taken |=> !epc_taken)
    else begin
      fail_count++;
      $error("epc_taken held high for two cycles");
    end

  assert property (@(posedge clk) !mem_wr |-> (system_bus_mask == '0))
    else begin
      fail_count++;
      $error("byte mask nonzero without a store");
    end

  // bus address comes straight from the ALU
  assert property (@(posedge clk) system_bus_addr == alu_o)
    else begin
      fail_count++;
      $error("system bus address differs from alu_o");
    end

endmodule

bind wb_stage wb_stage_props props_inst (
  .clk             (clk),
  .rst_n           (rst_n),
  .mem_wr          (mem_wr),
  .epc_taken       (epc_taken),
  .alu_o           (alu_o),
  .system_bus_addr (system_bus_addr),
  .system_bus_mask (system_bus_mask)
);

`default_nettype wire

// ==== verification/wb_stage_tb.sv ====
// writeback stage testbench with LFSR stimulus, reference models for the
// bus, load and CSR rules, and the trap entry / mret sequences
`timescale 1ns/100ps
`default_nettype none

module wb_stage_tb;
  import riscv_isa_pkg::*;
  import wb_cfg_pkg::*;

  logic                   clk;
  logic                   rst_n;
  logic                   mem_wr, mem_read, csr_reg_wr, csr_reg_r, is_mret;
  logic [xlen-1:0]        alu_o, pc, mem_wr_data, instruction, rdata1;
  wb_sel_e                wb_sel;
  logic [num_irq-1:0]     interrupt;
  logic [xlen-1:0]        wb_data, epc;
  logic                   epc_taken, system_bus_en, system_bus_rdwr;
  logic [xlen-1:0]        system_bus_addr, system_bus_wr_data, system_bus_rd_data;
  logic [byte_mask_w-1:0] system_bus_mask;
  logic [31:0]            lfsr_state;
  int                     checks;
  int                     errors;
  // stores first, then loads
  logic [2:0]             mem_ops [8] = '{funct3_sb, funct3_sh, funct3_sw, funct3_lb,
                                          funct3_lh, funct3_lw, funct3_lbu, funct3_lhu};

  wb_stage wb_stage_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_word();
    logic [31:0] w;
    logic        fb;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  // funct3[1:0] encodes log2 of the access size
  function automatic int access_bytes(input logic [2:0] f3);
    return f3[1] ? 4 : (f3[0] ? 2 : 1);
  endfunction

  function automatic logic [3:0] exp_mask(input logic [2:0] f3, input logic [1:0] off);
    logic [3:0] m;
    for (int b = 0; b < 4; b++) begin
      m[b] = (f3 == funct3_sw) || (f3 == funct3_sh && b[1] == off[1]) ||
             (f3 == funct3_sb && b[1:0] == off);
    end
    return m;
  endfunction

  // every lane repeats the store value at its own width
  function automatic logic [31:0] exp_store(input logic [2:0] f3, input logic [31:0] d);
    logic [31:0] w;
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = d[8 * (b % access_bytes(f3)) +: 8];
    end
    return w;
  endfunction

  function automatic logic [31:0] exp_load(input logic [2:0] f3, input logic [1:0] off,
                                           input logic [31:0] rd);
    logic [31:0] s;
    s = rd >> (8 * off);
    case (f3)
      funct3_lb:  return {{24{s[7]}}, s[7:0]};
      funct3_lbu: return {24'h0, s[7:0]};
      funct3_lh:  return {{16{s[15]}}, s[15:0]};
      funct3_lhu: return {16'h0, s[15:0]};
      default:    return rd;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  // csr instruction with the address in the immediate
  task automatic csr_access(input logic [11:0] addr, input logic wr, input logic [31:0] data);
    @(posedge clk);
    instruction <= {addr, 5'd1, 3'b001, 5'd1, 7'h73};
    csr_reg_wr  <= wr;
    csr_reg_r   <= !wr;
    rdata1      <= data;
    wb_sel      <= wb_csr;
    mem_wr      <= 1'b0;
    mem_read    <= 1'b0;
  endtask

  task automatic csr_read_check(input logic [11:0] addr, input logic [31:0] exp,
                                input string name);
    csr_access(addr, 1'b0, '0);
    @(negedge clk);
    check_value(name, wb_data, exp);
  endtask

  task automatic wait_redirect(input logic [31:0] target);
    int n;
    for (n = 1; n <= 10; n++) begin
      @(negedge clk);
      if (epc_taken) break;
    end
    if (n > 10) begin
      errors++;
      $display("timeout while waiting for epc_taken");
    end else begin
      check_value("epc_taken delay in cycles", 32'(n), 32'd1);
      check_value("epc", epc, target);
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] vec;
    logic [31:0] trap_pc;
    logic [31:0] ie_bit;
    logic [31:0] saved_bit;
    logic [2:0]  f3;
    logic        st;
    int          prop_fails;
    lfsr_state         = 32'h686256d3;
    checks             = 0;
    errors             = 0;
    ie_bit             = 32'(1) << mstatus_mie_bit;
    saved_bit          = 32'(1) << mstatus_mpie_bit;
    rst_n              = 1'b0;
    mem_wr             = 1'b0;
    mem_read           = 1'b0;
    csr_reg_wr         = 1'b0;
    csr_reg_r          = 1'b0;
    is_mret            = 1'b0;
    alu_o              = '0;
    pc                 = '0;
    mem_wr_data        = '0;
    instruction        = '0;
    rdata1             = '0;
    wb_sel             = wb_pc4;
    interrupt          = '0;
    system_bus_rd_data = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // pc+4 and ALU writeback
    for (int i = 0; i < 8; i++) begin
      a = lfsr_word();
      d = lfsr_word();
      @(posedge clk);
      alu_o  <= a;
      pc     <= d;
      wb_sel <= i[0] ? wb_alu : wb_pc4;
      @(negedge clk);
      check_value("wb_data", wb_data, i[0] ? a : d + 32'd4);
    end

    // each access width at every aligned offset
    for (int n = 0; n < 8; n++) begin
      f3 = mem_ops[n];
      st = (n < 3);
      for (int off = 0; off < 4; off += access_bytes(f3)) begin
        a = lfsr_word();
        d = lfsr_word();
        @(posedge clk);
        alu_o              <= {a[31:2], 2'(off)};
        mem_wr_data        <= d;
        system_bus_rd_data <= d;
        mem_wr             <= st;
        mem_read           <= !st;
        wb_sel             <= wb_load;
        instruction        <= {17'h0, f3, 12'h023};
        @(negedge clk);
        check_value("system_bus_en", 32'(system_bus_en), 32'd1);
        check_value("system_bus_rdwr", 32'(system_bus_rdwr), 32'(st));
        check_value("system_bus_mask", 32'(system_bus_mask),
                    st ? 32'(exp_mask(f3, 2'(off))) : 32'd0);
        if (st) begin
          check_value("system_bus_wr_data", system_bus_wr_data, exp_store(f3, d));
        end else begin
          check_value("wb_data", wb_data, exp_load(f3, 2'(off), d));
        end
      end
    end

    // live mip and an unmapped address
    @(posedge clk);
    interrupt <= 4'b1010;
    csr_read_check(csr_mip, 32'(4'b1010) << irq_cause_base, "wb_data (mip)");
    check_value("system_bus_en", 32'(system_bus_en), 32'd0);
    csr_read_check(12'h7c0, 32'd0, "wb_data (unlisted csr)");
    @(posedge clk);
    interrupt <= '0;

    vec = lfsr_word();
    csr_access(csr_mtvec, 1'b1, vec);
    csr_read_check(csr_mtvec, vec, "wb_data (mtvec)");
    csr_access(csr_mie, 1'b1, 32'hffffffff);
    csr_read_check(csr_mie, 32'(4'hf) << irq_cause_base, "wb_data (mie)");
    csr_access(csr_mstatus, 1'b1, ie_bit);
    csr_read_check(csr_mstatus, ie_bit, "wb_data (mstatus)");

    // interrupts 1 and 2 together, index 1 wins
    trap_pc = lfsr_word();
    @(posedge clk);
    csr_reg_r <= 1'b0;
    pc        <= trap_pc;
    interrupt <= 4'b0110;
    @(posedge clk);
    interrupt <= '0;
    wait_redirect(vec);
    csr_read_check(csr_mcause, {1'b1, 31'(irq_cause_base + 1)}, "wb_data (mcause)");
    csr_read_check(csr_mepc, trap_pc, "wb_data (mepc)");
    csr_read_check(csr_mstatus, saved_bit, "wb_data (mstatus after trap)");

    // return restores the global enable
    @(posedge clk);
    csr_reg_r <= 1'b0;
    is_mret   <= 1'b1;
    @(posedge clk);
    is_mret   <= 1'b0;
    wait_redirect(trap_pc);
    csr_read_check(csr_mstatus, ie_bit | saved_bit, "wb_data (mstatus after mret)");

    @(posedge clk);
    prop_fails = int'(wb_stage_inst.props_inst.fail_count);
    $display("checks %0d, check errors %0d, property failures %0d",
             checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
